/* Makefile */
# Verilator flow for the switchboard loopback

OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module sb_loopback_top

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_sb_loopback -Mdir $(OBJ)
	@out="$$(./$(OBJ)/Vtb_sb_loopback)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ)

/* common/sb_pkg.sv */
package sb_pkg;

    // ========================================
    // widths
    // ========================================

    localparam int SB_DATA_W = 256;
    localparam int SB_DEST_W = 32;
    localparam int MEM_WORD_W = 512;
    localparam int MEM_ADDR_W = 16;
    localparam int CSR_ADDR_W = 8;
    localparam int CSR_DATA_W = 32;

    // ========================================
    // ring entry layout in a memory word
    // ========================================

    // bits above the last flag are always zero
    localparam int ENTRY_DATA_LSB = 0;
    localparam int ENTRY_DEST_LSB = 256;
    localparam int ENTRY_LAST_BIT = 288;

    // ========================================
    // ring geometry
    // ========================================

    localparam int RING_DEPTH = 16;
    localparam int PTR_W = $clog2(RING_DEPTH);

    // entry k of a ring lives at base + k
    localparam logic [MEM_ADDR_W-1:0] RX_BASE = 16'h0000;
    localparam logic [MEM_ADDR_W-1:0] TX_BASE = 16'h0100;

    // ========================================
    // stream flow control
    // ========================================

    // receiver buffer depth, also the initial credit count of a sender
    localparam int STREAM_CREDITS = 4;
    localparam int CRED_W = $clog2(STREAM_CREDITS + 1);
    localparam int BUF_IDX_W = $clog2(STREAM_CREDITS);

    // ========================================
    // register offsets
    // ========================================

    // bit 0 of the control register is enable
    localparam logic [CSR_ADDR_W-1:0] CSR_CTRL = 8'h00;
    localparam logic [CSR_ADDR_W-1:0] CSR_RX_TAIL = 8'h04;
    localparam logic [CSR_ADDR_W-1:0] CSR_RX_HEAD = 8'h08;
    localparam logic [CSR_ADDR_W-1:0] CSR_TX_TAIL = 8'h0C;
    localparam logic [CSR_ADDR_W-1:0] CSR_TX_HEAD = 8'h10;

endpackage

/* common/sb_stream_if.sv */
`timescale 1ns/1ps

// packet link between blocks
// the sender spends one credit per valid cycle, the receiver
// pulses credit once for every entry leaving its buffer
interface sb_stream_if;
    import sb_pkg::*;

    logic [SB_DATA_W-1:0] data;
    logic [SB_DEST_W-1:0] dest;
    logic last;
    logic valid;
    logic credit;

    modport sender (
        output data,
        output dest,
        output last,
        output valid,
        input  credit
    );

    modport receiver (
        input  data,
        input  dest,
        input  last,
        input  valid,
        output credit
    );

endinterface

/* queues/sb_rx_queue_reader.sv */
`timescale 1ns/1ps

module sb_rx_queue_reader (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,

    input  logic [sb_pkg::PTR_W-1:0] rx_tail,
    output logic [sb_pkg::PTR_W-1:0] rx_head,

    output logic mem_rd_req,
    output logic [sb_pkg::MEM_ADDR_W-1:0] mem_rd_addr,
    input  logic mem_rd_valid,
    input  logic [sb_pkg::MEM_WORD_W-1:0] mem_rd_data,

    sb_stream_if.sender out
);
    import sb_pkg::*;

    // next ring slot to request, runs ahead of rx_head by the reads in flight
    logic [PTR_W-1:0] fetch_ptr;
    // free slots downstream, shared by reads in flight and packets
    // the modifier still holds
    logic [CRED_W-1:0] budget;
    logic issue;

    assign issue = enable && (fetch_ptr != rx_tail) && (budget != '0);

    // ========================================
    // request side and pointer bookkeeping
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_ptr <= '0;
            rx_head <= '0;
            budget <= CRED_W'(STREAM_CREDITS);
            mem_rd_req <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            mem_rd_req <= issue;
            out.valid <= mem_rd_valid;
            if (issue) begin
                fetch_ptr <= fetch_ptr + 1'b1;
            end
            if (mem_rd_valid) begin
                rx_head <= rx_head + 1'b1;
            end
            budget <= budget - CRED_W'(issue) + CRED_W'(out.credit);
        end
    end

    // ========================================
    // address and response unpacking
    // ========================================

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_rd_addr <= RX_BASE + MEM_ADDR_W'(fetch_ptr);
        end
        if (mem_rd_valid) begin
            out.data <= mem_rd_data[ENTRY_DATA_LSB +: SB_DATA_W];
            out.dest <= mem_rd_data[ENTRY_DEST_LSB +: SB_DEST_W];
            out.last <= mem_rd_data[ENTRY_LAST_BIT];
        end
    end

endmodule

/* queues/sb_tx_queue_writer.sv */
`timescale 1ns/1ps

module sb_tx_queue_writer (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,

    input  logic [sb_pkg::PTR_W-1:0] tx_head,
    output logic [sb_pkg::PTR_W-1:0] tx_tail,

    output logic mem_wr_en,
    output logic [sb_pkg::MEM_ADDR_W-1:0] mem_wr_addr,
    output logic [sb_pkg::MEM_WORD_W-1:0] mem_wr_data,
    input  logic mem_wr_ready,

    sb_stream_if.receiver in
);
    import sb_pkg::*;

    logic [SB_DATA_W-1:0] data_mem [STREAM_CREDITS];
    logic [SB_DEST_W-1:0] dest_mem [STREAM_CREDITS];
    logic last_mem [STREAM_CREDITS];
    logic [BUF_IDX_W-1:0] wr_idx;
    logic [BUF_IDX_W-1:0] rd_idx;
    logic [CRED_W-1:0] count;
    logic [PTR_W-1:0] tail_next;
    logic [MEM_WORD_W-1:0] head_word;
    logic ring_full;
    logic start;
    logic taken;

    // one slot stays empty so a full ring is told apart from an empty one
    assign tail_next = tx_tail + 1'b1;
    assign ring_full = (tail_next == tx_head);
    assign start = !mem_wr_en && (count != '0) && enable && !ring_full;
    assign taken = mem_wr_en && mem_wr_ready;

    always_comb begin
        head_word = '0;
        head_word[ENTRY_DATA_LSB +: SB_DATA_W] = data_mem[rd_idx];
        head_word[ENTRY_DEST_LSB +: SB_DEST_W] = dest_mem[rd_idx];
        head_word[ENTRY_LAST_BIT] = last_mem[rd_idx];
    end

    // mem_wr_en stays up until the memory takes the word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wr_en <= 1'b0;
            tx_tail <= '0;
            in.credit <= 1'b0;
            count <= '0;
            wr_idx <= '0;
            rd_idx <= '0;
        end else begin
            in.credit <= taken;
            if (start) begin
                mem_wr_en <= 1'b1;
            end else if (taken) begin
                mem_wr_en <= 1'b0;
            end
            if (taken) begin
                tx_tail <= tail_next;
                rd_idx <= rd_idx + 1'b1;
            end
            if (in.valid) begin
                wr_idx <= wr_idx + 1'b1;
            end
            count <= count + CRED_W'(in.valid) - CRED_W'(taken);
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            data_mem[wr_idx] <= in.data;
            dest_mem[wr_idx] <= in.dest;
            last_mem[wr_idx] <= in.last;
        end
        if (start) begin
            mem_wr_addr <= TX_BASE + MEM_ADDR_W'(tx_tail);
            mem_wr_data <= head_word;
        end
    end

endmodule

/* src.f */
common/sb_pkg.sv
common/sb_stream_if.sv
verilog/sb_csr.sv
queues/sb_rx_queue_reader.sv
verilog/sb_packet_modifier.sv
queues/sb_tx_queue_writer.sv
verilog/sb_loopback_top.sv
testbench/tb_mem_model.sv
testbench/tb_sb_loopback.sv

/* testbench/tb_mem_model.sv */
`timescale 1ns/1ps

// host memory with in-order read responses after a per-request latency
module tb_mem_model (
    input  logic clk,
    input  logic rst_n,

    input  logic rd_req,
    input  logic [15:0] rd_addr,
    output logic rd_valid,
    output logic [511:0] rd_data,
    input  logic [4:0] rd_latency,

    input  logic wr_en,
    input  logic [15:0] wr_addr,
    input  logic [511:0] wr_data,
    input  logic wr_ready,

    // backdoor used by the host side of the testbench to fill the receive ring
    input  logic host_we,
    input  logic [15:0] host_addr,
    input  logic [511:0] host_wdata
);

    // both rings fit below word 512
    logic [511:0] mem [512];
    logic [15:0] addr_q [$];
    int due_q [$];
    int cycle;

    always @(posedge clk) begin
        if (!rst_n) begin
            cycle <= 0;
            rd_valid <= 1'b0;
            addr_q.delete();
            due_q.delete();
        end else begin
            cycle <= cycle + 1;
            if (rd_req) begin
                addr_q.push_back(rd_addr);
                due_q.push_back(cycle + int'(rd_latency));
            end
            // at most one response per cycle, oldest first
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                rd_valid <= 1'b1;
                rd_data <= mem[addr_q[0][8:0]];
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                rd_valid <= 1'b0;
            end
            if (wr_en && wr_ready) begin
                mem[wr_addr[8:0]] <= wr_data;
            end
            if (host_we) begin
                mem[host_addr[8:0]] <= host_wdata;
            end
        end
    end

endmodule

/* testbench/tb_sb_loopback.sv */
`timescale 1ns/1ps

module tb_sb_loopback;
    import sb_pkg::*;

    localparam int TOTAL_PKTS = 64;
    localparam logic [31:0] LFSR_POLY = 32'h80200003;

    logic clk;
    logic rst_n;
    logic rst_d;
    logic cfg_valid;
    logic cfg_write;
    logic [CSR_ADDR_W-1:0] cfg_addr;
    logic [CSR_DATA_W-1:0] cfg_wdata;
    logic [CSR_DATA_W-1:0] cfg_rdata;
    logic cfg_rvalid;
    logic mem_rd_req;
    logic [MEM_ADDR_W-1:0] mem_rd_addr;
    logic mem_rd_valid;
    logic [MEM_WORD_W-1:0] mem_rd_data;
    logic mem_wr_en;
    logic [MEM_ADDR_W-1:0] mem_wr_addr;
    logic [MEM_WORD_W-1:0] mem_wr_data;
    logic mem_wr_ready;
    logic [4:0] rd_latency;
    logic host_we;
    logic [15:0] host_addr;
    logic [511:0] host_wdata;
    logic long_latency;
    logic rd_pend;
    logic [31:0] stim_lfsr;
    logic [31:0] mem_lfsr;
    logic [PTR_W-1:0] rx_tail_sw;
    logic [MEM_WORD_W-1:0] exp_q [$];
    int rd_count;
    int wr_count;
    int outstanding;
    int max_outstanding;
    int errors;
    int test_err_base;
    int tests_run;
    int tests_ok;

    sb_loopback_top i_dut (.*);

    tb_mem_model i_mem (
        .clk (clk), .rst_n (rst_n),
        .rd_req (mem_rd_req), .rd_addr (mem_rd_addr), .rd_valid (mem_rd_valid),
        .rd_data (mem_rd_data), .rd_latency (rd_latency),
        .wr_en (mem_wr_en), .wr_addr (mem_wr_addr), .wr_data (mem_wr_data),
        .wr_ready (mem_wr_ready),
        .host_we (host_we), .host_addr (host_addr), .host_wdata (host_wdata)
    );

    function automatic logic lfsr_step(inout logic [31:0] state);
        logic b;
        b = state[0];
        state = state >> 1;
        if (b) begin
            state = state ^ LFSR_POLY;
        end
        return b;
    endfunction

    // transmit word expected for a receive entry
    function automatic logic [MEM_WORD_W-1:0] expected_word(logic [MEM_WORD_W-1:0] entry);
        logic [MEM_WORD_W-1:0] w;
        w = '0;
        for (int b = 0; b < SB_DATA_W / 8; b++) begin
            w[ENTRY_DATA_LSB + b*8 +: 8] = entry[ENTRY_DATA_LSB + b*8 +: 8] + 8'd1;
        end
        w[ENTRY_DEST_LSB +: SB_DEST_W] = entry[ENTRY_DEST_LSB +: SB_DEST_W];
        w[ENTRY_LAST_BIT] = entry[ENTRY_LAST_BIT];
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (200 * TOTAL_PKTS + 1000) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("tests failed");
        $finish;
    end

    // ========================================
    // memory-side stimulus and monitors
    // ========================================

    always @(posedge clk) begin
        rst_d <= rst_n;
        rd_pend <= cfg_valid && !cfg_write;
        mem_wr_ready <= !(lfsr_step(mem_lfsr) && lfsr_step(mem_lfsr));
        if (long_latency) begin
            rd_latency <= 5'd12;
        end else begin
            rd_latency <= 5'd1 + {4'd0, lfsr_step(mem_lfsr)} + {4'd0, lfsr_step(mem_lfsr)} * 2;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_rd_req) begin
                assert (mem_rd_addr == RX_BASE + MEM_ADDR_W'(rd_count % RING_DEPTH)) else begin
                    errors++;
                    $display("mismatch at %0t: mem_rd_addr expected %h got %h", $time,
                             RX_BASE + MEM_ADDR_W'(rd_count % RING_DEPTH), mem_rd_addr);
                end
                rd_count++;
            end
            outstanding = outstanding + int'(mem_rd_req) - int'(mem_rd_valid);
            if (outstanding > max_outstanding) begin
                max_outstanding = outstanding;
            end
            assert (outstanding <= STREAM_CREDITS) else begin
                errors++;
                $display("mismatch at %0t: reads outstanding expected <= %0d got %0d",
                         $time, STREAM_CREDITS, outstanding);
            end
            if (mem_wr_en && mem_wr_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("a memory write was taken at %0t with no entry posted", $time);
                end else begin
                    assert (mem_wr_data == exp_q[0]) else begin
                        errors++;
                        $display("mismatch at %0t: mem_wr_data expected %h got %h",
                                 $time, exp_q[0], mem_wr_data);
                    end
                    void'(exp_q.pop_front());
                end
                assert (mem_wr_addr == TX_BASE + MEM_ADDR_W'(wr_count % RING_DEPTH)) else begin
                    errors++;
                    $display("mismatch at %0t: mem_wr_addr expected %h got %h", $time,
                             TX_BASE + MEM_ADDR_W'(wr_count % RING_DEPTH), mem_wr_addr);
                end
                wr_count++;
            end
        end
    end

    assert property (@(posedge clk) !rst_d |-> (!mem_rd_req && !mem_wr_en && !cfg_rvalid))
    else begin
        errors++;
        $display("outputs not idle in or right after reset at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) cfg_rvalid == rd_pend) else begin
        errors++;
        $display("mismatch at %0t: cfg_rvalid expected %b got %b", $time, rd_pend, cfg_rvalid);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     (mem_wr_en && !mem_wr_ready) |=> mem_wr_en) else begin
        errors++;
        $display("mem_wr_en dropped before the write was taken at %0t", $time);
    end

    // ========================================
    // host tasks
    // ========================================

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input int data);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_write <= 1'b1;
        cfg_addr <= addr;
        cfg_wdata <= CSR_DATA_W'(data);
        @(posedge clk);
        cfg_valid <= 1'b0;
        cfg_write <= 1'b0;
    endtask

    task automatic check_csr(input logic [CSR_ADDR_W-1:0] addr, input int expected,
                             input string name);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_write <= 1'b0;
        cfg_addr <= addr;
        @(posedge clk);
        cfg_valid <= 1'b0;
        @(posedge clk);
        assert (cfg_rdata == CSR_DATA_W'(expected)) else begin
            errors++;
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected,
                     cfg_rdata);
        end
    endtask

    task automatic post_entries(input int n);
        logic [MEM_WORD_W-1:0] word;
        for (int i = 0; i < n; i++) begin
            word = '0;
            for (int b = 0; b < SB_DATA_W; b++) begin
                word[ENTRY_DATA_LSB + b] = lfsr_step(stim_lfsr);
            end
            for (int b = 0; b < SB_DEST_W; b++) begin
                word[ENTRY_DEST_LSB + b] = lfsr_step(stim_lfsr);
            end
            word[ENTRY_LAST_BIT] = lfsr_step(stim_lfsr);
            @(posedge clk);
            host_we <= 1'b1;
            host_addr <= RX_BASE + 16'(rx_tail_sw);
            host_wdata <= word;
            exp_q.push_back(expected_word(word));
            rx_tail_sw = rx_tail_sw + 1'b1;
        end
        @(posedge clk);
        host_we <= 1'b0;
        csr_write(CSR_RX_TAIL, int'(rx_tail_sw));
    endtask

    task automatic wait_count(input int target, input bit writes);
        int t;
        t = 0;
        while ((writes ? wr_count : rd_count) < target && t < 200 * TOTAL_PKTS) begin
            @(posedge clk);
            t++;
        end
        if ((writes ? wr_count : rd_count) < target) begin
            errors++;
            $display("timed out waiting for %0d %s", target, writes ? "writes" : "reads");
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial begin
        int base;
        rst_n = 1'b0;
        rst_d = 1'b1;
        cfg_valid = 1'b0;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        mem_wr_ready = 1'b0;
        rd_latency = 5'd1;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        long_latency = 1'b0;
        stim_lfsr = 32'hec4a;
        mem_lfsr = 32'hec4a;
        rx_tail_sw = '0;
        rd_count = 0;
        wr_count = 0;
        outstanding = 0;
        max_outstanding = 0;
        errors = 0;
        test_err_base = 0;
        tests_run = 0;
        tests_ok = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        check_csr(CSR_RX_HEAD, 0, "CSR_RX_HEAD");
        check_csr(CSR_TX_TAIL, 0, "CSR_TX_TAIL");
        finish_test("reset");

        post_entries(8);
        repeat (40) @(posedge clk);
        assert (rd_count == 0) else begin
            errors++;
            $display("mem_rd_req was raised while enable was clear");
        end
        csr_write(CSR_CTRL, 1);
        wait_count(8, 1'b1);
        check_csr(CSR_RX_HEAD, int'(rx_tail_sw), "CSR_RX_HEAD");
        csr_write(CSR_TX_HEAD, wr_count % RING_DEPTH);
        finish_test("enable");

        // crosses the wrap of both rings, then brings both pointers back to zero
        post_entries(12);
        wait_count(20, 1'b1);
        csr_write(CSR_TX_HEAD, wr_count % RING_DEPTH);
        post_entries(12);
        wait_count(32, 1'b1);
        csr_write(CSR_TX_HEAD, wr_count % RING_DEPTH);
        finish_test("transform_and_order");

        base = wr_count;
        post_entries(10);
        wait_count(base + 10, 1'b0);
        post_entries(10);
        wait_count(base + RING_DEPTH - 1, 1'b1);
        repeat (60) @(posedge clk);
        assert (wr_count == base + RING_DEPTH - 1) else begin
            errors++;
            $display("mismatch at %0t: write count expected %0d got %0d", $time,
                     base + RING_DEPTH - 1, wr_count);
        end
        check_csr(CSR_TX_TAIL, RING_DEPTH - 1, "CSR_TX_TAIL");
        csr_write(CSR_TX_HEAD, wr_count % RING_DEPTH);
        wait_count(base + 20, 1'b1);
        csr_write(CSR_TX_HEAD, wr_count % RING_DEPTH);
        finish_test("back_pressure");

        long_latency <= 1'b1;
        post_entries(12);
        wait_count(base + 32, 1'b1);
        csr_write(CSR_TX_HEAD, wr_count % RING_DEPTH);
        long_latency <= 1'b0;
        $display("most reads outstanding: %0d", max_outstanding);
        finish_test("credit_bound");

        $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* verilog/sb_csr.sv */
`timescale 1ns/1ps

module sb_csr (
    input  logic clk,
    input  logic rst_n,

    input  logic cfg_valid,
    input  logic cfg_write,
    input  logic [sb_pkg::CSR_ADDR_W-1:0] cfg_addr,
    input  logic [sb_pkg::CSR_DATA_W-1:0] cfg_wdata,
    output logic [sb_pkg::CSR_DATA_W-1:0] cfg_rdata,
    output logic cfg_rvalid,

    output logic enable,
    output logic [sb_pkg::PTR_W-1:0] rx_tail,
    output logic [sb_pkg::PTR_W-1:0] tx_head,
    input  logic [sb_pkg::PTR_W-1:0] rx_head,
    input  logic [sb_pkg::PTR_W-1:0] tx_tail
);
    import sb_pkg::*;

    logic rd_cycle;
    logic wr_cycle;
    logic [CSR_DATA_W-1:0] rd_word;

    assign rd_cycle = cfg_valid && !cfg_write;
    assign wr_cycle = cfg_valid && cfg_write;

    // host-written registers, read-only offsets simply fall to default
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b0;
            rx_tail <= '0;
            tx_head <= '0;
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= rd_cycle;
            if (wr_cycle) begin
                case (cfg_addr)
                    CSR_CTRL:    enable <= cfg_wdata[0];
                    CSR_RX_TAIL: rx_tail <= cfg_wdata[PTR_W-1:0];
                    CSR_TX_HEAD: tx_head <= cfg_wdata[PTR_W-1:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    // read mux, unknown offsets read as zero
    always_comb begin
        case (cfg_addr)
            CSR_CTRL:    rd_word = CSR_DATA_W'(enable);
            CSR_RX_TAIL: rd_word = CSR_DATA_W'(rx_tail);
            CSR_RX_HEAD: rd_word = CSR_DATA_W'(rx_head);
            CSR_TX_TAIL: rd_word = CSR_DATA_W'(tx_tail);
            CSR_TX_HEAD: rd_word = CSR_DATA_W'(tx_head);
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_cycle) begin
            cfg_rdata <= rd_word;
        end
    end

endmodule

/* verilog/sb_loopback_top.sv */
`timescale 1ns/1ps

module sb_loopback_top (
    input  logic clk,
    input  logic rst_n,

    // host register port
    input  logic cfg_valid,
    input  logic cfg_write,
    input  logic [sb_pkg::CSR_ADDR_W-1:0] cfg_addr,
    input  logic [sb_pkg::CSR_DATA_W-1:0] cfg_wdata,
    output logic [sb_pkg::CSR_DATA_W-1:0] cfg_rdata,
    output logic cfg_rvalid,

    // memory read port, responses in request order
    output logic mem_rd_req,
    output logic [sb_pkg::MEM_ADDR_W-1:0] mem_rd_addr,
    input  logic mem_rd_valid,
    input  logic [sb_pkg::MEM_WORD_W-1:0] mem_rd_data,

    // memory write port
    output logic mem_wr_en,
    output logic [sb_pkg::MEM_ADDR_W-1:0] mem_wr_addr,
    output logic [sb_pkg::MEM_WORD_W-1:0] mem_wr_data,
    input  logic mem_wr_ready
);
    import sb_pkg::*;

    logic enable;
    logic [PTR_W-1:0] rx_tail;
    logic [PTR_W-1:0] rx_head;
    logic [PTR_W-1:0] tx_head;
    logic [PTR_W-1:0] tx_tail;

    sb_stream_if rx_stream ();
    sb_stream_if tx_stream ();

    sb_csr i_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_valid  (cfg_valid),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid),
        .enable     (enable),
        .rx_tail    (rx_tail),
        .tx_head    (tx_head),
        .rx_head    (rx_head),
        .tx_tail    (tx_tail)
    );

    sb_rx_queue_reader i_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .rx_tail      (rx_tail),
        .rx_head      (rx_head),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .out          (rx_stream)
    );

    sb_packet_modifier i_modifier (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (rx_stream),
        .out   (tx_stream)
    );

    sb_tx_queue_writer i_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .tx_head      (tx_head),
        .tx_tail      (tx_tail),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_ready (mem_wr_ready),
        .in           (tx_stream)
    );

endmodule

/* verilog/sb_packet_modifier.sv */
`timescale 1ns/1ps

module sb_packet_modifier (
    input  logic clk,
    input  logic rst_n,
    sb_stream_if.receiver in,
    sb_stream_if.sender out
);
    import sb_pkg::*;

    logic [SB_DATA_W-1:0] data_mem [STREAM_CREDITS];
    logic [SB_DEST_W-1:0] dest_mem [STREAM_CREDITS];
    logic last_mem [STREAM_CREDITS];
    logic [BUF_IDX_W-1:0] wr_idx;
    logic [BUF_IDX_W-1:0] rd_idx;
    logic [CRED_W-1:0] count;
    logic [CRED_W-1:0] credits;
    logic [SB_DATA_W-1:0] inc_data;
    logic send;

    // every payload byte goes up by one and wraps at 256
    always_comb begin
        for (int b = 0; b < SB_DATA_W / 8; b++) begin
            inc_data[b*8 +: 8] = in.data[b*8 +: 8] + 8'd1;
        end
    end

    // the oldest entry leaves as soon as a downstream credit is held,
    // and its slot is handed back upstream in the same cycle
    assign send = (count != '0) && (credits != '0);
    assign out.valid = send;
    assign out.data = data_mem[rd_idx];
    assign out.dest = dest_mem[rd_idx];
    assign out.last = last_mem[rd_idx];
    assign in.credit = send;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count <= '0;
            credits <= CRED_W'(STREAM_CREDITS);
        end else begin
            if (in.valid) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (send) begin
                rd_idx <= rd_idx + 1'b1;
            end
            count <= count + CRED_W'(in.valid) - CRED_W'(send);
            credits <= credits - CRED_W'(send) + CRED_W'(out.credit);
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            data_mem[wr_idx] <= inc_data;
            dest_mem[wr_idx] <= in.dest;
            last_mem[wr_idx] <= in.last;
        end
    end

endmodule
